// File: vlog.f
hw/mem_pkg.sv
hw/pmp_pkg.sv
hw/pmp_check.sv
hw/word_ram.sv
hw/arbiter.sv
hw/mem_top.sv
tests/mem_top_props.sv
tests/tb_mem_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_top -f vlog.f -o tb_mem_top

# Keep running after an assertion error so the testbench ends the run.
./obj_dir/tb_mem_top +verilator+error+limit+100

// File: tests/tb_mem_top.sv
module tb_mem_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int depth = 256;
  localparam int timeout_cycles = 20;

  logic clk;
  logic rst;
  logic imem_valid, imem_instr, imem_ready, imem_error;
  logic dmem_valid, dmem_instr, dmem_ready, dmem_error;
  pmp_pkg::mode_t imem_mode, dmem_mode;
  mem_pkg::addr_t imem_addr, dmem_addr;
  mem_pkg::word_t imem_wdata, dmem_wdata, imem_rdata, dmem_rdata;
  mem_pkg::strb_t imem_wstrb, dmem_wstrb;

  mem_pkg::word_t model [depth]; // Expected memory contents.
  bit             known [depth];
  int             seed = 90;

  mem_top #(
    .depth_words(depth), .user_base(32'h100), .user_limit(32'h300), .rom_limit(32'h80)
  ) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on a failed check");
  endtask

  task automatic check_value(input string name, input mem_pkg::word_t got,
                             input mem_pkg::word_t exp);
    assert (got === exp)
      else stop_with_failure($sformatf("[FAIL] %0t %s: got %h, expected %h",
                                       $time, name, got, exp));
  endtask

  task automatic check_idle();
    check_value("imem_ready", {31'b0, imem_ready}, '0);
    check_value("dmem_ready", {31'b0, dmem_ready}, '0);
    check_value("imem_error", {31'b0, imem_error}, '0);
    check_value("dmem_error", {31'b0, dmem_error}, '0);
    check_value("mem_valid", {31'b0, u_dut.mem_valid}, '0);
  endtask

  // One request on one port checked against the model.
  task automatic transfer(input bit on_dmem, input pmp_pkg::mode_t mode,
                          input mem_pkg::addr_t addr, input mem_pkg::word_t wdata,
                          input mem_pkg::strb_t wstrb, input bit exp_error);
    int             cycles;
    int             idx;
    bit             ready;
    bit             err;
    mem_pkg::word_t rdata;
    idx = int'((addr >> 2) % depth);
    @(posedge clk);
    if (on_dmem) begin
      dmem_valid <= 1'b1;
      dmem_instr <= 1'b0;
      dmem_mode  <= mode;
      dmem_addr  <= addr;
      dmem_wdata <= wdata;
      dmem_wstrb <= wstrb;
    end else begin
      imem_valid <= 1'b1;
      imem_instr <= 1'b1; // Fetch.
      imem_mode  <= mode;
      imem_addr  <= addr;
      imem_wdata <= wdata;
      imem_wstrb <= wstrb;
    end
    cycles = 0;
    ready = 1'b0;
    while (!ready) begin
      @(negedge clk);
      ready = on_dmem ? dmem_ready : imem_ready;
      if (!ready) begin
        cycles++;
        if (cycles > timeout_cycles) stop_with_failure("timeout waiting for ready");
      end
    end
    err   = on_dmem ? dmem_error : imem_error;
    rdata = on_dmem ? dmem_rdata : imem_rdata;
    check_value("ready latency", mem_pkg::word_t'(cycles), 1);
    check_value(on_dmem ? "dmem_error" : "imem_error", {31'b0, err}, {31'b0, exp_error});
    if (exp_error) begin
      check_value(on_dmem ? "dmem_rdata" : "imem_rdata", rdata, '0);
    end else if (wstrb == '0 && known[idx]) begin
      check_value(on_dmem ? "dmem_rdata" : "imem_rdata", rdata, model[idx]);
    end
    if (!exp_error) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) model[idx][8*b +: 8] = wdata[8*b +: 8];
      end
      if (wstrb == 4'hf) known[idx] = 1'b1;
    end
    @(posedge clk);
    if (on_dmem) dmem_valid <= 1'b0;
    else imem_valid <= 1'b0;
  endtask

  // Fetch and store to one address in the same cycle.
  task automatic race_both(input mem_pkg::addr_t addr, input mem_pkg::word_t wdata);
    int             cycle;
    int             i_done;
    int             d_done;
    int             idx;
    bit             i_now;
    bit             d_now;
    mem_pkg::word_t i_rdata;
    idx = int'((addr >> 2) % depth);
    @(posedge clk);
    imem_valid <= 1'b1;
    imem_instr <= 1'b1;
    imem_mode  <= pmp_pkg::m_mode;
    imem_addr  <= addr;
    imem_wstrb <= '0;
    dmem_valid <= 1'b1;
    dmem_instr <= 1'b0;
    dmem_mode  <= pmp_pkg::m_mode;
    dmem_addr  <= addr;
    dmem_wdata <= wdata;
    dmem_wstrb <= 4'hf;
    cycle = 0;
    i_done = 0;
    d_done = 0;
    i_rdata = '0;
    while (i_done == 0 || d_done == 0) begin
      @(negedge clk);
      cycle++;
      if (cycle > timeout_cycles) stop_with_failure("timeout waiting for both ports");
      d_now = dmem_ready;
      i_now = imem_ready;
      if (d_now) d_done = cycle;
      if (i_now) begin
        i_done = cycle;
        i_rdata = imem_rdata;
      end
      @(posedge clk);
      if (d_now) dmem_valid <= 1'b0;
      if (i_now) imem_valid <= 1'b0;
    end
    assert (d_done < i_done) else stop_with_failure("imem was served before dmem");
    model[idx] = wdata; // Fetch sees the new word.
    known[idx] = 1'b1;
    check_value("imem_rdata", i_rdata, model[idx]);
  endtask

  initial begin
    mem_pkg::word_t rnd;
    mem_pkg::addr_t addr;
    int             tmp;
    rst = 1'b0;
    {imem_valid, imem_instr, dmem_valid, dmem_instr} = '0;
    imem_mode = pmp_pkg::m_mode;
    dmem_mode = pmp_pkg::m_mode;
    {imem_addr, dmem_addr, imem_wdata, dmem_wdata} = '0;
    {imem_wstrb, dmem_wstrb} = '0;
    for (int i = 0; i < depth; i++) known[i] = 1'b0;

    for (int c = 0; c < 14; c++) begin
      @(posedge clk);
      if (c == 9) rst <= 1'b1;
      @(negedge clk);
      check_idle();
    end

    for (int i = 0; i < 8; i++) begin
      addr = 32'h100 + 32'(4 * i);
      rnd = $random(seed);
      transfer(1'b1, pmp_pkg::m_mode, addr, rnd, 4'hf, 1'b0);
      rnd = $random(seed);
      tmp = $random(seed);
      transfer(1'b1, pmp_pkg::m_mode, addr, rnd, tmp[3:0], 1'b0); // Random lanes.
      transfer(1'b1, pmp_pkg::m_mode, addr, '0, '0, 1'b0);
      transfer(1'b0, pmp_pkg::m_mode, addr, '0, '0, 1'b0);
    end

    rnd = $random(seed);
    race_both(32'h104, rnd);

    // User accesses outside the window.
    rnd = $random(seed);
    transfer(1'b1, pmp_pkg::m_mode, 32'h3f0, rnd, 4'hf, 1'b0);
    rnd = $random(seed);
    transfer(1'b1, pmp_pkg::u_mode, 32'h3f0, rnd, 4'hf, 1'b1);
    transfer(1'b1, pmp_pkg::u_mode, 32'h3f0, '0, '0, 1'b1);
    transfer(1'b0, pmp_pkg::u_mode, 32'h3f0, '0, '0, 1'b1);
    transfer(1'b1, pmp_pkg::m_mode, 32'h3f0, '0, '0, 1'b0);
    transfer(1'b1, pmp_pkg::u_mode, 32'h108, '0, '0, 1'b0);
    transfer(1'b0, pmp_pkg::u_mode, 32'h108, '0, '0, 1'b0);

    rnd = $random(seed);
    transfer(1'b1, pmp_pkg::m_mode, 32'h40, rnd, 4'hf, 1'b1); // Read-only area.
    transfer(1'b1, pmp_pkg::m_mode, 32'h40, '0, '0, 1'b0);

    repeat (3) @(posedge clk);
    @(negedge clk);
    if (u_dut.u_props.fail_count != 0) begin
      stop_with_failure("a handshake assertion failed");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  // Catch assertion failures while the run goes on.
  always @(negedge clk) begin
    if (u_dut.u_props.fail_count != 0) stop_with_failure("a handshake assertion failed");
  end

endmodule

// File: tests/mem_top_props.sv
module mem_top_props (
  input logic clk,
  input logic rst,
  input logic imem_ready,
  input logic imem_error,
  input logic dmem_ready,
  input logic dmem_error,
  input logic mem_valid,
  input logic pmp_error
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0; // Failed assertions so far.

  // Only one owner is answered per cycle.
  a_one_ready: assert property (@(posedge clk) disable iff (!rst)
    !(imem_ready && dmem_ready))
    else begin
      fail_count++;
      $error("ready high on both ports in one cycle");
    end

  a_imem_error: assert property (@(posedge clk) disable iff (!rst)
    imem_error |-> imem_ready)
    else begin
      fail_count++;
      $error("imem_error without imem_ready");
    end

  a_dmem_error: assert property (@(posedge clk) disable iff (!rst)
    dmem_error |-> dmem_ready)
    else begin
      fail_count++;
      $error("dmem_error without dmem_ready");
    end

  a_gate: assert property (@(posedge clk) disable iff (!rst)
    !(mem_valid && pmp_error)) // Refused access reaching memory.
    else begin
      fail_count++;
      $error("mem_valid high while pmp_error is high");
    end

  a_dmem_once: assert property (@(posedge clk) disable iff (!rst)
    dmem_ready |=> !dmem_ready)
    else begin
      fail_count++;
      $error("dmem_ready high in two cycles in a row");
    end

endmodule

bind mem_top mem_top_props u_props (
  .clk(clk), .rst(rst),
  .imem_ready(imem_ready), .imem_error(imem_error),
  .dmem_ready(dmem_ready), .dmem_error(dmem_error),
  .mem_valid(mem_valid), .pmp_error(pmp_error)
);

// File: hw/mem_top.sv
module mem_top #(
  parameter int             depth_words = 256,
  parameter mem_pkg::addr_t user_base   = 32'h100,
  parameter mem_pkg::addr_t user_limit  = 32'h300,
  parameter mem_pkg::addr_t rom_limit   = 32'h80
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           imem_valid,
  input  logic           imem_instr,
  input  pmp_pkg::mode_t imem_mode,
  input  mem_pkg::addr_t imem_addr,
  input  mem_pkg::word_t imem_wdata,
  input  mem_pkg::strb_t imem_wstrb,
  output logic           imem_ready,
  output logic           imem_error,
  output mem_pkg::word_t imem_rdata,
  input  logic           dmem_valid,
  input  logic           dmem_instr,
  input  pmp_pkg::mode_t dmem_mode,
  input  mem_pkg::addr_t dmem_addr,
  input  mem_pkg::word_t dmem_wdata,
  input  mem_pkg::strb_t dmem_wstrb,
  output logic           dmem_ready,
  output logic           dmem_error,
  output mem_pkg::word_t dmem_rdata
);

  logic           pmp_valid;
  logic           pmp_instr;
  pmp_pkg::mode_t pmp_mode;
  mem_pkg::addr_t pmp_addr;
  mem_pkg::strb_t pmp_wstrb;
  logic           pmp_error;
  logic           mem_valid;
  mem_pkg::addr_t mem_addr;
  mem_pkg::word_t mem_wdata;
  mem_pkg::strb_t mem_wstrb;
  logic           mem_ready;
  mem_pkg::word_t mem_rdata;

  arbiter u_arbiter (
    .clk, .rst,
    .imem_valid, .imem_instr, .imem_mode, .imem_addr, .imem_wdata, .imem_wstrb,
    .imem_ready, .imem_error, .imem_rdata,
    .dmem_valid, .dmem_instr, .dmem_mode, .dmem_addr, .dmem_wdata, .dmem_wstrb,
    .dmem_ready, .dmem_error, .dmem_rdata,
    .pmp_valid, .pmp_instr, .pmp_mode, .pmp_addr, .pmp_wstrb, .pmp_error,
    .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb, .mem_ready, .mem_rdata
  );

  pmp_check #(
    .user_base (user_base),
    .user_limit(user_limit),
    .rom_limit (rom_limit)
  ) u_pmp_check (
    .pmp_valid, .pmp_instr, .pmp_mode, .pmp_addr, .pmp_wstrb, .pmp_error
  );

  word_ram #(.depth_words(depth_words)) u_word_ram (
    .clk, .rst,
    .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb, .mem_ready, .mem_rdata
  );

endmodule

// File: hw/arbiter.sv
module arbiter (
  input  logic             clk,
  input  logic             rst,
  // Instruction fetch port.
  input  logic             imem_valid,
  input  logic             imem_instr,
  input  pmp_pkg::mode_t   imem_mode,
  input  mem_pkg::addr_t   imem_addr,
  input  mem_pkg::word_t   imem_wdata,
  input  mem_pkg::strb_t   imem_wstrb,
  output logic             imem_ready,
  output logic             imem_error,
  output mem_pkg::word_t   imem_rdata,
  // Data load/store port.
  input  logic             dmem_valid,
  input  logic             dmem_instr,
  input  pmp_pkg::mode_t   dmem_mode,
  input  mem_pkg::addr_t   dmem_addr,
  input  mem_pkg::word_t   dmem_wdata,
  input  mem_pkg::strb_t   dmem_wstrb,
  output logic             dmem_ready,
  output logic             dmem_error,
  output mem_pkg::word_t   dmem_rdata,
  // Protection checker.
  output logic             pmp_valid,
  output logic             pmp_instr,
  output pmp_pkg::mode_t   pmp_mode,
  output mem_pkg::addr_t   pmp_addr,
  output mem_pkg::strb_t   pmp_wstrb,
  input  logic             pmp_error,
  // Word memory.
  output logic             mem_valid,
  output mem_pkg::addr_t   mem_addr,
  output mem_pkg::word_t   mem_wdata,
  output mem_pkg::strb_t   mem_wstrb,
  input  logic             mem_ready,
  input  mem_pkg::word_t   mem_rdata
);

  mem_pkg::access_e r_access; // Owner of the access in flight.
  logic             r_error;  // Checker refused it last cycle.
  mem_pkg::access_e sel;
  logic             done;
  logic             free;
  logic             imem_req;
  logic             dmem_req;
  mem_pkg::word_t   sel_wdata;

  // The access in flight is answered this cycle.
  assign done = (r_access != mem_pkg::no_access) && (r_error || mem_ready);
  assign free = (r_access == mem_pkg::no_access) || done;

  // A port seeing its ready still holds the finished request.
  assign imem_req = imem_valid && !(done && r_access == mem_pkg::instr_access);
  assign dmem_req = dmem_valid && !(done && r_access == mem_pkg::data_access);

  always_comb begin
    sel = mem_pkg::no_access;
    if (free) begin
      if (dmem_req) sel = mem_pkg::data_access; // Data first.
      else if (imem_req) sel = mem_pkg::instr_access;
    end
  end

  always_comb begin
    pmp_valid = sel != mem_pkg::no_access;
    pmp_instr = 1'b0;
    pmp_mode  = pmp_pkg::m_mode;
    pmp_addr  = '0;
    pmp_wstrb = '0;
    sel_wdata = '0;
    if (sel == mem_pkg::data_access) begin
      pmp_instr = dmem_instr;
      pmp_mode  = dmem_mode;
      pmp_addr  = dmem_addr;
      pmp_wstrb = dmem_wstrb;
      sel_wdata = dmem_wdata;
    end else if (sel == mem_pkg::instr_access) begin
      pmp_instr = imem_instr;
      pmp_mode  = imem_mode;
      pmp_addr  = imem_addr;
      pmp_wstrb = imem_wstrb;
      sel_wdata = imem_wdata;
    end
  end

  // Refused requests never reach memory.
  assign mem_valid = pmp_valid && !pmp_error;
  assign mem_addr  = mem_valid ? pmp_addr : '0;
  assign mem_wdata = mem_valid ? sel_wdata : '0;
  assign mem_wstrb = mem_valid ? pmp_wstrb : '0;

  always_ff @(posedge clk) begin
    if (!rst) begin
      r_access <= mem_pkg::no_access;
      r_error  <= 1'b0;
    end else if (sel != mem_pkg::no_access) begin
      r_access <= sel;
      r_error  <= pmp_error;
    end else if (done) begin
      r_access <= mem_pkg::no_access;
      r_error  <= 1'b0;
    end
  end

  // Responses go only to the owner.
  always_comb begin
    imem_ready = (r_access == mem_pkg::instr_access) && done;
    imem_error = (r_access == mem_pkg::instr_access) && r_error;
    imem_rdata = (imem_ready && !r_error) ? mem_rdata : '0;
    dmem_ready = (r_access == mem_pkg::data_access) && done;
    dmem_error = (r_access == mem_pkg::data_access) && r_error;
    dmem_rdata = (dmem_ready && !r_error) ? mem_rdata : '0;
  end

endmodule

// File: hw/word_ram.sv
module word_ram #(
  parameter int depth_words = 256
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           mem_valid,
  input  mem_pkg::addr_t mem_addr,
  input  mem_pkg::word_t mem_wdata,
  input  mem_pkg::strb_t mem_wstrb,
  output logic           mem_ready,
  output mem_pkg::word_t mem_rdata
);

  localparam int idx_w = (depth_words > 1) ? $clog2(depth_words) : 1;

  mem_pkg::word_t   ram [depth_words];
  mem_pkg::addr_t   word_addr;
  logic [idx_w-1:0] idx;

  // Word index wraps around the array.
  assign word_addr = (mem_addr >> 2) % depth_words;
  assign idx       = word_addr[idx_w-1:0];

  always_ff @(posedge clk) begin
    if (mem_valid) begin
      mem_rdata <= ram[idx]; // Old contents.
      for (int b = 0; b < $bits(mem_pkg::strb_t); b++) begin
        if (mem_wstrb[b]) ram[idx][8*b +: 8] <= mem_wdata[8*b +: 8];
      end
    end
  end

  // Answer one cycle after the request.
  always_ff @(posedge clk) begin
    if (!rst) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= mem_valid;
    end
  end

endmodule

// File: hw/pmp_check.sv
module pmp_check #(
  parameter mem_pkg::addr_t user_base  = 32'h100,
  parameter mem_pkg::addr_t user_limit = 32'h300,
  parameter mem_pkg::addr_t rom_limit  = 32'h80
) (
  input  logic           pmp_valid,
  input  logic           pmp_instr,
  input  pmp_pkg::mode_t pmp_mode,
  input  mem_pkg::addr_t pmp_addr,
  input  mem_pkg::strb_t pmp_wstrb,
  output logic           pmp_error
);

  pmp_pkg::cause_e cause;
  logic            in_window;
  logic            in_rom;
  logic            is_write;
  logic            is_user;

  assign in_window = (pmp_addr >= user_base) && (pmp_addr < user_limit);
  assign in_rom    = pmp_addr < rom_limit;
  assign is_write  = |pmp_wstrb;
  assign is_user   = pmp_mode == pmp_pkg::u_mode;

  always_comb begin
    cause = pmp_pkg::fault_none;
    if (pmp_valid) begin
      if (is_write && in_rom) begin
        cause = pmp_pkg::fault_rom; // Any mode.
      end else if (is_user && !in_window) begin
        if (pmp_instr) cause = pmp_pkg::fault_fetch;
        else if (is_write) cause = pmp_pkg::fault_store;
        else cause = pmp_pkg::fault_load;
      end
    end
  end

  // Machine mode only trips on the read-only area.
  assign pmp_error = cause != pmp_pkg::fault_none;

endmodule

// File: hw/pmp_pkg.sv
package pmp_pkg;

  // Privilege mode as carried on the request ports.
  typedef logic [1:0] mode_t;

  localparam mode_t u_mode = 2'b00; // User.
  localparam mode_t m_mode = 2'b11; // Machine.

  // Why a request was refused.
  typedef enum logic [2:0] {
    fault_none  = 3'd0,
    fault_fetch = 3'd1, // User fetch outside the window.
    fault_load  = 3'd2, // User load outside the window.
    fault_store = 3'd3, // User store outside the window.
    fault_rom   = 3'd4  // Write into the read-only area.
  } cause_e;

endpackage

// File: hw/mem_pkg.sv
package mem_pkg;

  // Bus widths on the memory side.
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // Byte address.
  typedef logic [addr_w-1:0] addr_t;

  // One memory word.
  typedef logic [data_w-1:0] word_t;

  // Byte lanes to write, all zero for a read.
  typedef logic [strb_w-1:0] strb_t;

  // Owner of the access held by the arbiter.
  typedef enum logic [1:0] {
    no_access    = 2'd0,
    instr_access = 2'd1,
    data_access  = 2'd2
  } access_e;

endpackage
